//--- rtl/simonBlockFifo.sv
module simonBlockFifo
(
	input logic clk, nR,
	input logic resValid, resLast,
	input logic [7:0] resInfo,
	input logic [1:0][simonPkg::wordW-1:0] resWords,
	output logic fifoSpace,
	output logic blkValid, blkLast,
	output logic [7:0] blkInfo,
	output logic [1:0][simonPkg::wordW-1:0] blkWords,
	input logic blkRead
);

logic [1:0][simonPkg::wordW-1:0] memWords [2];
logic [7:0] memInfo [2];
logic memLast [2];
logic wrPtr, rdPtr, pop;
logic [1:0] count;

assign pop = blkRead && blkValid;
assign fifoSpace = count != 2'd2;
assign blkValid = count != 2'd0;
assign blkWords = memWords[rdPtr];
assign blkInfo = memInfo[rdPtr];
assign blkLast = memLast[rdPtr];

always_ff @(posedge clk, negedge nR)
begin
	if(~nR)
	begin
		wrPtr <= 1'b0;
		rdPtr <= 1'b0;
		count <= 2'd0;
	end
	else
	begin
		if(resValid)
			wrPtr <= ~wrPtr;
		if(pop)
			rdPtr <= ~rdPtr;
		count <= count + {1'b0, resValid} - {1'b0, pop};
	end
end

always_ff @(posedge clk)
begin
	if(resValid)	// the core never writes into a full buffer.
	begin
		memWords[wrPtr] <= resWords;
		memInfo[wrPtr] <= resInfo;
		memLast[wrPtr] <= resLast;
	end
end

endmodule

//--- rtl/simonDataIn.sv
module simonDataIn
(
	input logic clk, nR,
	input logic [simonPktPkg::pktBytes-1:0][7:0] inPkt,
	input logic inValid,
	output logic inRead,
	output logic cmdValid, cmdKey, cmdDec, cmdLast,
	output logic [7:0] cmdInfo,
	output logic [1:0][simonPkg::wordW-1:0] cmdWords,
	input logic cmdReady
);

logic [simonPkg::keyWords-1:0][simonPkg::wordW-1:0] inWords;
logic [1:0][simonPkg::wordW-1:0] hiWords;
logic [7:0] info;
logic pktOk, newPkt, dec;

assign inWords = inPkt[simonPktPkg::countByte-1:0];
assign info = inPkt[simonPktPkg::infoByte];
assign pktOk = (info[3:0] == simonPktPkg::modeSimon) && !info[simonPktPkg::infoDirBit];
assign newPkt = inValid && !inRead && !cmdValid;	// packet still held during the inRead pulse.
assign dec = info[simonPktPkg::infoDecBit] && !info[simonPktPkg::infoKeyBit];

always_ff @(posedge clk, negedge nR)
begin
	if(~nR)
	begin
		inRead <= 1'b0;
		cmdValid <= 1'b0;
		cmdLast <= 1'b0;
	end
	else
	begin
		inRead <= 1'b0;
		if(newPkt)
		begin
			cmdValid <= pktOk;
			cmdLast <= !info[simonPktPkg::infoKeyBit] && !info[simonPktPkg::infoTwoBit];
			inRead <= !pktOk;	// bad packets are dropped here.
		end
		else if(cmdValid && cmdReady)
		begin
			if(cmdLast)
			begin
				cmdValid <= 1'b0;
				inRead <= 1'b1;
			end
			cmdLast <= 1'b1;
		end
	end
end

// key halves go unswapped, data blocks swap for decrypt.
always_ff @(posedge clk)
begin
	if(newPkt)
	begin
		cmdKey <= info[simonPktPkg::infoKeyBit];
		cmdDec <= dec;
		cmdInfo <= info;
		cmdWords <= dec ? {inWords[0], inWords[1]} : inWords[1:0];
		hiWords <= inWords[3:2];
	end
	else if(cmdValid && cmdReady)
	begin
		cmdWords <= cmdDec ? {hiWords[0], hiWords[1]} : hiWords;
	end
end

endmodule

//--- rtl/simonDataOut.sv
module simonDataOut
(
	input logic clk, nR,
	input logic blkValid, blkLast,
	input logic [7:0] blkInfo,
	input logic [1:0][simonPkg::wordW-1:0] blkWords,
	output logic blkRead,
	output logic [simonPktPkg::pktBytes-1:0][7:0] outPkt,
	output logic outDone,
	input logic outRead
);

typedef enum logic [1:0] {waitSt, loadSt, readSt, writeSt} stateT;
stateT state, next;

logic [3:0][simonPkg::wordW-1:0] data;
logic [7:0] info, pktCount;
logic slot;	// high once block 0 is placed.

always_ff @(posedge clk, negedge nR)
begin
	if(~nR)
	begin
		state <= waitSt;
		slot <= 1'b0;
		blkRead <= 1'b0;
		outDone <= 1'b0;
		pktCount <= '0;
	end
	else
	begin
		state <= next;
		blkRead <= (state == readSt);	// pop lands one cycle after the read.
		if(outDone && outRead)
			outDone <= 1'b0;
		if(state == readSt)
			slot <= !blkLast;
		if(state == writeSt)
		begin
			outDone <= 1'b1;
			pktCount <= pktCount + 1'b1;
		end
	end
end

always_ff @(posedge clk)
begin
	if(state == loadSt)
	begin
		info <= blkInfo;
		info[simonPktPkg::infoDirBit] <= 1'b1;
		data <= '0;
	end
	if(state == readSt && !info[simonPktPkg::infoKeyBit])
	begin
		data[{slot, 1'b0} +: 2] <= info[simonPktPkg::infoDecBit] ?
			{blkWords[0], blkWords[1]} : blkWords;	// undo the decrypt swap.
	end
	if(state == writeSt)
	begin
		outPkt[simonPktPkg::infoByte] <= info;
		outPkt[simonPktPkg::countByte] <= pktCount;
		outPkt[simonPktPkg::countByte-1:0] <= data;
	end
end

always_comb
begin
	next = state;
	unique case(state)
	waitSt:
	begin
		if(blkValid && !blkRead && !outDone)	// hold off while the last packet is unread.
			next = slot ? readSt : loadSt;
	end
	loadSt:
	begin
		next = readSt;
	end
	readSt:
	begin
		next = blkLast ? writeSt : waitSt;
	end
	writeSt:
	begin
		next = waitSt;
	end
	default: next = waitSt;
	endcase
end

endmodule

//--- rtl/simonPkg.sv
package simonPkg;

localparam int wordW = 32;
localparam int keyWords = 4;
localparam int rounds = 44;
localparam int roundIdxW = 6;

// index of the final round, also the top entry of the round-key array.
localparam logic [roundIdxW-1:0] lastRound = roundIdxW'(rounds - 1);

// constant term of the key schedule, 2^32 - 4.
localparam logic [wordW-1:0] roundConst = {{(wordW-2){1'b1}}, 2'b00};

// z3 sequence, bit i holds z3[i].
localparam logic [61:0] zSeq = 62'h3c2c_e512_07a6_35db;

endpackage

//--- rtl/simonPktPkg.sv
package simonPktPkg;

localparam int pktBytes = 18;
localparam int infoByte = 17;
localparam int countByte = 16;	// bytes below this hold words 3..0.

localparam logic [3:0] modeSimon = 4'h6;	// low nibble of the info byte.

// info byte flags.
localparam int infoDirBit = 4;	// set on output packets.
localparam int infoKeyBit = 5;
localparam int infoDecBit = 6;	// block words travel swapped.
localparam int infoTwoBit = 7;

endpackage

//--- rtl/simonRoundCore.sv
module simonRoundCore
(
	input logic clk, nR,
	input logic cmdValid, cmdKey, cmdDec, cmdLast,
	input logic [7:0] cmdInfo,
	input logic [1:0][simonPkg::wordW-1:0] cmdWords,
	output logic cmdReady,
	input logic fifoSpace,
	output logic resValid, resLast,
	output logic [7:0] resInfo,
	output logic [1:0][simonPkg::wordW-1:0] resWords
);

typedef enum logic [1:0] {idle, sched, run} stateT;
stateT state;

logic [simonPkg::wordW-1:0] roundKey [simonPkg::rounds];
logic [simonPkg::keyWords-1:0][simonPkg::wordW-1:0] win;	// k[i] .. k[i+3].
logic [simonPkg::roundIdxW-1:0] cnt, keyIdx;
logic [simonPkg::wordW-1:0] blkHi, blkLo, fOut, nextHi, curKey;
logic [simonPkg::wordW-1:0] schedTmp, newKey, zWord;
logic [7:0] tag;
logic dec, last, take;

function automatic logic [simonPkg::wordW-1:0] rotl(input logic [simonPkg::wordW-1:0] v,
	input int s);
	return (v << s) | (v >> (simonPkg::wordW - s));
endfunction

assign take = (state == idle) && cmdValid && cmdReady;

// with the words swapped, the inverse round takes the same form.
assign keyIdx = dec ? simonPkg::lastRound - cnt : cnt;
assign curKey = roundKey[keyIdx];
assign fOut = (rotl(blkHi, 1) & rotl(blkHi, 8)) ^ rotl(blkHi, 2);
assign nextHi = blkLo ^ fOut ^ curKey;

assign schedTmp = rotl(win[3], simonPkg::wordW - 3) ^ win[1];
assign zWord = {{(simonPkg::wordW-1){1'b0}}, simonPkg::zSeq[cnt]};
assign newKey = simonPkg::roundConst ^ zWord ^ win[0] ^ schedTmp
	^ rotl(schedTmp, simonPkg::wordW - 1);

always_ff @(posedge clk, negedge nR)
begin
	if(~nR)
	begin
		state <= idle;
		cnt <= '0;
		cmdReady <= 1'b0;
		resValid <= 1'b0;
	end
	else
	begin
		resValid <= 1'b0;
		unique case(state)
		idle:
		begin
			cmdReady <= fifoSpace && !resValid;	// wait for the result write to land.
			if(take)
			begin
				cnt <= '0;
				if(!cmdKey)
				begin
					state <= run;
					cmdReady <= 1'b0;
				end
				else if(cmdLast)
				begin
					state <= sched;
					cmdReady <= 1'b0;
				end
			end
		end
		sched, run:
		begin
			cnt <= cnt + 1'b1;
			if(cnt == simonPkg::lastRound)
			begin
				state <= idle;
				resValid <= 1'b1;
			end
		end
		default: state <= idle;
		endcase
	end
end

always_ff @(posedge clk)
begin
	if(take)
	begin
		tag <= cmdInfo;
		dec <= cmdDec;
		last <= cmdLast;
		if(!cmdKey)
			{blkHi, blkLo} <= cmdWords;
		else if(cmdLast)
			win[3:2] <= cmdWords;
		else
			win[1:0] <= cmdWords;
	end
	if(state == sched)
	begin
		roundKey[cnt] <= win[0];
		win <= {newKey, win[3:1]};
	end
	if(state == run)
	begin
		blkHi <= nextHi;
		blkLo <= blkHi;
	end
	if(state != idle && cnt == simonPkg::lastRound)
	begin
		resWords <= (state == run) ? {nextHi, blkHi} : '0;	// key ack carries zeros.
		resInfo <= tag;
		resLast <= last;
	end
end

endmodule

//--- rtl/simonTop.sv
module simonTop
(
	input logic clk, nR,
	input logic [simonPktPkg::pktBytes-1:0][7:0] inPkt,
	input logic inValid,
	output logic inRead,
	output logic [simonPktPkg::pktBytes-1:0][7:0] outPkt,
	output logic outDone,
	input logic outRead
);

logic cmdValid, cmdKey, cmdDec, cmdLast, cmdReady;
logic [7:0] cmdInfo;
logic [1:0][simonPkg::wordW-1:0] cmdWords;

logic resValid, resLast, fifoSpace;
logic [7:0] resInfo;
logic [1:0][simonPkg::wordW-1:0] resWords;

logic blkValid, blkLast, blkRead;
logic [7:0] blkInfo;
logic [1:0][simonPkg::wordW-1:0] blkWords;

simonDataIn dataIn
(
	.clk(clk), .nR(nR),
	.inPkt(inPkt), .inValid(inValid), .inRead(inRead),
	.cmdValid(cmdValid), .cmdKey(cmdKey), .cmdDec(cmdDec), .cmdLast(cmdLast),
	.cmdInfo(cmdInfo), .cmdWords(cmdWords), .cmdReady(cmdReady)
);

simonRoundCore roundCore
(
	.clk(clk), .nR(nR),
	.cmdValid(cmdValid), .cmdKey(cmdKey), .cmdDec(cmdDec), .cmdLast(cmdLast),
	.cmdInfo(cmdInfo), .cmdWords(cmdWords), .cmdReady(cmdReady),
	.fifoSpace(fifoSpace),
	.resValid(resValid), .resLast(resLast), .resInfo(resInfo), .resWords(resWords)
);

simonBlockFifo blockFifo
(
	.clk(clk), .nR(nR),
	.resValid(resValid), .resLast(resLast), .resInfo(resInfo), .resWords(resWords),
	.fifoSpace(fifoSpace),
	.blkValid(blkValid), .blkLast(blkLast), .blkInfo(blkInfo), .blkWords(blkWords),
	.blkRead(blkRead)
);

simonDataOut dataOut
(
	.clk(clk), .nR(nR),
	.blkValid(blkValid), .blkLast(blkLast), .blkInfo(blkInfo), .blkWords(blkWords),
	.blkRead(blkRead),
	.outPkt(outPkt), .outDone(outDone), .outRead(outRead)
);

endmodule

//--- simonTop.f
rtl/simonPkg.sv
rtl/simonPktPkg.sv
rtl/simonDataIn.sv
rtl/simonRoundCore.sv
rtl/simonBlockFifo.sv
rtl/simonDataOut.sv
rtl/simonTop.sv
verif/simonTb.sv

//--- verif/simonTb.sv
module simonTb;

localparam int clkPeriod = 8;
localparam int numEntries = 10;
localparam int pktW = simonPktPkg::pktBytes * 8;
localparam int entryW = 2 * pktW + 4;
localparam int dropBit = 2 * pktW;	// low bit of the leading flag digit.
localparam int cyclesPerBlock = 60;
localparam int timeoutMargin = 200;
localparam int maxStall = 100;	// longest random hold on outRead.
localparam int quietCycles = 60;
localparam int seedValue = 32'h3c6;

logic clk, nR;
logic [simonPktPkg::pktBytes-1:0][7:0] inPkt;
logic inValid, inRead;
logic [simonPktPkg::pktBytes-1:0][7:0] outPkt;
logic outDone, outRead;

logic [entryW-1:0] testData [numEntries];
int cycleCount = 0;
int cycleLimit;
int seed;

simonTop dut
(
	.clk(clk), .nR(nR),
	.inPkt(inPkt), .inValid(inValid), .inRead(inRead),
	.outPkt(outPkt), .outDone(outDone), .outRead(outRead)
);

always #(clkPeriod / 2) clk = ~clk;

always @(posedge clk)
begin
	cycleCount <= cycleCount + 1;
	if(cycleCount >= cycleLimit)
	begin
		$display("FAIL: timeout, output packets missing");
		$display("FAIL: see errors above");
		$fatal(1);
	end
end

task automatic checkEq(input string name, input logic [pktW-1:0] expected,
	input logic [pktW-1:0] actual);
	if(actual !== expected)
	begin
		$display("FAIL %s expected %h actual %h", name, expected, actual);
		$display("FAIL: see errors above");
		$fatal(1);
	end
endtask

function automatic int computeLimit();
	logic [simonPktPkg::pktBytes-1:0][7:0] pkt;
	int blocks = 0;
	int outputs = 0;
	for(int i = 0; i < numEntries; i++)
	begin
		pkt = testData[i][2*pktW-1:pktW];
		blocks += pkt[simonPktPkg::infoByte][simonPktPkg::infoTwoBit] ? 2 : 1;
		if(!testData[i][dropBit])
			outputs++;
	end
	return cyclesPerBlock * blocks + maxStall * outputs + timeoutMargin + quietCycles;
endfunction

// one packet per entry, held until inRead.
task automatic feedInputs();
	int waitCycles;
	for(int i = 0; i < numEntries; i++)
	begin
		@(posedge clk);
		#1;
		inPkt = testData[i][2*pktW-1:pktW];
		inValid = 1'b1;
		waitCycles = 0;
		@(negedge clk);
		while(!inRead)
		begin
			@(negedge clk);
			waitCycles++;
		end
		if(testData[i][dropBit])
			checkEq($sformatf("drop latency entry %0d", i), 1, waitCycles);
		@(posedge clk);
		#1;
		inValid = 1'b0;
	end
endtask

task automatic collectOutputs();
	int stall;
	for(int i = 0; i < numEntries; i++)
	begin
		if(!testData[i][dropBit])
		begin
			@(negedge clk);
			while(!outDone)
				@(negedge clk);
			checkEq($sformatf("output packet entry %0d", i), testData[i][pktW-1:0], outPkt);
			stall = $urandom % maxStall;	// long holds fill the FIFO.
			repeat(stall) @(posedge clk);
			@(posedge clk);
			#1;
			outRead = 1'b1;
			@(posedge clk);
			#1;
			outRead = 1'b0;
		end
	end
endtask

initial
begin
	clk = 1'b0;
	nR = 1'b0;
	inPkt = '0;
	inValid = 1'b0;
	outRead = 1'b0;
	seed = seedValue;
	void'($urandom(seed));
	$readmemh("verif/simonTestdata.hex", testData);
	cycleLimit = computeLimit();
	repeat(2) @(posedge clk);
	checkEq("reset inRead", 0, inRead);
	checkEq("reset outDone", 0, outDone);
	#1;
	nR = 1'b1;
	fork
		feedInputs();
		collectOutputs();
	join
	// dropped packets must not show up late.
	repeat(quietCycles)
	begin
		@(negedge clk);
		checkEq("no extra output packet", 0, outDone);
	end
	$display("PASS: all tests");
	$finish;
end

endmodule

//--- verif/simonTestdata.hex
// drop flag, input packet (info count w3 w2 w1 w0),
// expected output packet (info count w3 w2 w1 w0), zeros for dropped rows
0_26_00_1b1a1918_13121110_0b0a0908_03020100_36_00_00000000_00000000_00000000_00000000
0_06_00_deadbeef_cafef00d_656b696c_20646e75_16_01_00000000_00000000_44c8fc20_b9dfa07a
1_05_00_00000000_00000000_656b696c_20646e75_00_00_00000000_00000000_00000000_00000000
0_c6_00_44c8fc20_b9dfa07a_44c8fc20_b9dfa07a_d6_02_656b696c_20646e75_656b696c_20646e75
1_16_00_00000000_00000000_44c8fc20_b9dfa07a_00_00_00000000_00000000_00000000_00000000
0_86_00_656b696c_20646e75_656b696c_20646e75_96_03_44c8fc20_b9dfa07a_44c8fc20_b9dfa07a
0_46_00_00000000_00000000_44c8fc20_b9dfa07a_56_04_00000000_00000000_656b696c_20646e75
1_a7_00_656b696c_20646e75_656b696c_20646e75_00_00_00000000_00000000_00000000_00000000
0_26_2a_1b1a1918_13121110_0b0a0908_03020100_36_05_00000000_00000000_00000000_00000000
0_06_00_00000000_00000000_656b696c_20646e75_16_06_00000000_00000000_44c8fc20_b9dfa07a
